// ==== angle_solver/dab_angle_solver.sv ====
`default_nettype none

module dab_angle_solver
(
  input  wire       trigger,
  input  wire       arst_n,
  operand_if.sink   opnd,
  angle_if.source   ang
);

  logic [1:0]                        state;
  logic                              ok_c;          // both denominators > 0
  logic                              div_start;
  logic                              div_done;
  logic signed [dab_pkg::DIV_W-1:0] div_dividend;
  logic signed [dab_pkg::DIV_W-1:0] div_divisor;
  logic signed [dab_pkg::DIV_W-1:0] div_quotient;
  logic signed [dab_pkg::DIV_W-1:0] phi_num_q;     // kept for second division
  logic signed [dab_pkg::DIV_W-1:0] phi_den_q;

  assign ok_c       = (opnd.tau_den > 0) && (opnd.phi_den > 0);
  assign opnd.ready = (state == dab_pkg::ST_IDLE);  // low until result leaves

  // tau division fed straight from the operand bus and phi division from the copy
  assign div_start = (state == dab_pkg::ST_IDLE && opnd.valid && ok_c) ||
                     (state == dab_pkg::ST_TAU && div_done);
  assign div_dividend = (state == dab_pkg::ST_IDLE) ? opnd.tau_num : phi_num_q;
  assign div_divisor  = (state == dab_pkg::ST_IDLE) ? opnd.tau_den : phi_den_q;

  seq_divider u_div
  (
    .trigger  (trigger),
    .arst_n   (arst_n),
    .start    (div_start),
    .dividend (div_dividend),
    .divisor  (div_divisor),
    .quotient (div_quotient),
    .done     (div_done)
  );

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge trigger or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state     <= dab_pkg::ST_IDLE;
      ang.valid <= 1'b0;
    end
    else
    begin
      case (state)
        dab_pkg::ST_IDLE:
        begin
          if (opnd.valid)
          begin
            if (ok_c)
              state <= dab_pkg::ST_TAU;
            else
            begin
              state     <= dab_pkg::ST_OUT;  // bad denominator skips both divisions
              ang.valid <= 1'b1;
            end
          end
        end
        dab_pkg::ST_TAU:
        begin
          if (div_done)
            state <= dab_pkg::ST_PHI;
        end
        dab_pkg::ST_PHI:
        begin
          if (div_done)
          begin
            state     <= dab_pkg::ST_OUT;
            ang.valid <= 1'b1;
          end
        end
        default:  // ST_OUT
        begin
          if (ang.ready)
          begin
            state     <= dab_pkg::ST_IDLE;
            ang.valid <= 1'b0;
          end
        end
      endcase
    end
  end

  // result and operand copies
  always_ff @(posedge trigger)
  begin
    if (state == dab_pkg::ST_IDLE && opnd.valid)
    begin
      phi_num_q <= opnd.phi_num;
      phi_den_q <= opnd.phi_den;
      ang.ok    <= ok_c;
    end
    if (state == dab_pkg::ST_TAU && div_done)
      ang.tau2_full <= div_quotient;
    if (state == dab_pkg::ST_PHI && div_done)
      ang.phi_full <= div_quotient - dab_pkg::ANGLE_HALF_PI + (ang.tau2_full >>> 1);
  end

  // one division at a time on the shared divider
  a_div_no_restart : assert property (@(posedge trigger) disable iff (!arst_n)
    div_start |-> !u_div.busy);

endmodule

`default_nettype wire

// ==== angle_solver/seq_divider.sv ====
`default_nettype none

module seq_divider
(
  input  wire                                 trigger,
  input  wire                                 arst_n,
  input  wire                                 start,
  input  wire signed [dab_pkg::DIV_W-1:0]    dividend,
  input  wire signed [dab_pkg::DIV_W-1:0]    divisor,
  output logic signed [dab_pkg::DIV_W-1:0]   quotient,
  output logic                                done
);

  logic [dab_pkg::DIV_W-1:0]     rem_q;    // partial remainder
  logic [dab_pkg::DIV_W-1:0]     quo_q;    // dividend out, quotient bits in
  logic [dab_pkg::DIV_W-1:0]     dsr_q;    // divisor magnitude
  logic                          neg_q;    // quotient sign
  logic                          busy;
  logic [dab_pkg::DIV_CNT_W-1:0] count;    // steps left
  logic [dab_pkg::DIV_W-1:0]     dvd_mag;
  logic [dab_pkg::DIV_W-1:0]     dsr_mag;
  logic [dab_pkg::DIV_W+1:0]     trial;    // shifted remainder minus divisor

  assign dvd_mag = dividend[dab_pkg::DIV_W-1] ? -dividend : dividend;
  assign dsr_mag = divisor[dab_pkg::DIV_W-1] ? -divisor : divisor;

  assign trial = {1'b0, rem_q, quo_q[dab_pkg::DIV_W-1]} - {2'b00, dsr_q};

  ////////////////////////////////////////////////////////////////////////////
  // control, DIV_W steps then one sign cycle
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge trigger or negedge arst_n)
  begin
    if (!arst_n)
    begin
      busy  <= 1'b0;
      done  <= 1'b0;
      count <= '0;
    end
    else
    begin
      done <= 1'b0;  // single pulse
      if (start)
      begin
        busy  <= 1'b1;
        count <= dab_pkg::DIV_W[dab_pkg::DIV_CNT_W-1:0];
      end
      else if (busy)
      begin
        if (count == '0)
        begin
          busy <= 1'b0;
          done <= 1'b1;
        end
        else
          count <= count - 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge trigger)
  begin
    if (start)
    begin
      rem_q <= '0;
      quo_q <= dvd_mag;
      dsr_q <= dsr_mag;
      neg_q <= dividend[dab_pkg::DIV_W-1] ^ divisor[dab_pkg::DIV_W-1];
    end
    else if (busy && count != '0)
    begin
      if (!trial[dab_pkg::DIV_W+1])  // divisor fits, keep difference
      begin
        rem_q <= trial[dab_pkg::DIV_W-1:0];
        quo_q <= {quo_q[dab_pkg::DIV_W-2:0], 1'b1};
      end
      else  // restore
      begin
        rem_q <= {rem_q[dab_pkg::DIV_W-2:0], quo_q[dab_pkg::DIV_W-1]};
        quo_q <= {quo_q[dab_pkg::DIV_W-2:0], 1'b0};
      end
    end
    else if (busy)
      quotient <= neg_q ? -quo_q : quo_q;  // truncation toward zero
  end

endmodule

`default_nettype wire

// ==== common/dab_if.sv ====
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// input stage -> solver
////////////////////////////////////////////////////////////////////////////

interface operand_if;
  logic                              valid;    // operands held until taken
  logic                              ready;    // solver idle
  logic signed [dab_pkg::DIV_W-1:0] tau_num;  // 2*(255*vdc1 - 3*fs)
  logic signed [dab_pkg::DIV_W-1:0] tau_den;  // 11*vdc2
  logic signed [dab_pkg::DIV_W-1:0] phi_num;  // 5*fs*iref
  logic signed [dab_pkg::DIV_W-1:0] phi_den;  // 255*vdc1 - 3*fs

  modport source
  (
    output valid, tau_num, tau_den, phi_num, phi_den,
    input  ready
  );

  modport sink
  (
    input  valid, tau_num, tau_den, phi_num, phi_den,
    output ready
  );
endinterface

////////////////////////////////////////////////////////////////////////////
// solver -> mode selector
////////////////////////////////////////////////////////////////////////////

interface angle_if;
  logic                              valid;
  logic                              ready;
  logic signed [dab_pkg::DIV_W-1:0] tau2_full;  // untruncated tau2 in counts
  logic signed [dab_pkg::DIV_W-1:0] phi_full;   // untruncated phi in counts
  logic                              ok;         // denominators were positive

  modport source
  (
    output valid, tau2_full, phi_full, ok,
    input  ready
  );

  modport sink
  (
    input  valid, tau2_full, phi_full, ok,
    output ready
  );
endinterface

`default_nettype wire

// ==== common/dab_pkg.sv ====
`default_nettype none

package dab_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int VOLT_W    = 14;  // vdc1, vdc2, iref, signed samples
  localparam int FS_W      = 19;  // switching frequency, signed
  localparam int ANGLE_W   = 9;   // tau1, tau2, phi outputs
  localparam int MODE_W    = 2;   // modo code
  localparam int DIV_W     = 48;  // products and divider operands
  localparam int DIV_CNT_W = $clog2(DIV_W + 1);  // divider step counter

  ////////////////////////////////////////////////////////////////////////////
  // angle scaling, 255 counts per pi
  ////////////////////////////////////////////////////////////////////////////

  localparam int ANGLE_PI      = 255;
  localparam int ANGLE_HALF_PI = 128;  // pi/2, rounded up

  ////////////////////////////////////////////////////////////////////////////
  // converter gains
  ////////////////////////////////////////////////////////////////////////////

  localparam int TURNS_NUM = 11;  // n = 11/2
  localparam int TURNS_DEN = 2;
  localparam int C2_GAIN   = 3;   // fs weight in the tau2 numerator
  localparam int PHI_GAIN  = 5;   // fs*iref weight in the phi numerator

  // outputs after reset
  localparam logic signed [ANGLE_W-1:0] RST_TAU1 = 9'sd255;
  localparam logic signed [ANGLE_W-1:0] RST_TAU2 = 9'sd147;
  localparam logic signed [ANGLE_W-1:0] RST_PHI  = -9'sd9;

  // mode codes, same numbering as the full four-mode controller
  localparam logic [MODE_W-1:0] MODE_HALF = 2'd1;  // tau1 held at pi
  localparam logic [MODE_W-1:0] MODE_HOLD = 2'd3;  // keep last angles

  // solver FSM states
  localparam logic [1:0] ST_IDLE = 2'd0;  // waiting for operands
  localparam logic [1:0] ST_TAU  = 2'd1;  // tau division running
  localparam logic [1:0] ST_PHI  = 2'd2;  // phi division running
  localparam logic [1:0] ST_OUT  = 2'd3;  // result offered downstream

endpackage

`default_nettype wire

// ==== dab_modulator.f ====
common/dab_pkg.sv
common/dab_if.sv
angle_solver/seq_divider.sv
angle_solver/dab_angle_solver.sv
rtl/dab_input_stage.sv
rtl/dab_mode_select.sv
rtl/dab_modulator.sv
verification/tb_dab_modulator.sv

// ==== rtl/dab_input_stage.sv ====
`default_nettype none

module dab_input_stage
(
  input  wire                               trigger,
  input  wire                               arst_n,
  input  wire                               sample_valid,
  input  wire signed [dab_pkg::VOLT_W-1:0] vdc1,
  input  wire signed [dab_pkg::VOLT_W-1:0] vdc2,
  input  wire signed [dab_pkg::VOLT_W-1:0] iref,
  input  wire signed [dab_pkg::FS_W-1:0]   fs,
  output logic                              sample_ready,
  operand_if.source                         opnd
);

  logic signed [dab_pkg::DIV_W-1:0] vdc1_w;  // sign extended inputs
  logic signed [dab_pkg::DIV_W-1:0] vdc2_w;
  logic signed [dab_pkg::DIV_W-1:0] iref_w;
  logic signed [dab_pkg::DIV_W-1:0] fs_w;
  logic signed [dab_pkg::DIV_W-1:0] phi_den_c;  // shared by both equations
  logic                              take;

  assign vdc1_w = vdc1;
  assign vdc2_w = vdc2;
  assign iref_w = iref;
  assign fs_w   = fs;

  // pi*vdc1 - c2*fs, also the base of the tau numerator
  assign phi_den_c = dab_pkg::ANGLE_PI * vdc1_w - dab_pkg::C2_GAIN * fs_w;

  // room for a new sample when empty or being drained this edge
  assign sample_ready = !opnd.valid || opnd.ready;
  assign take         = sample_valid && sample_ready;

  always_ff @(posedge trigger or negedge arst_n)
  begin
    if (!arst_n)
      opnd.valid <= 1'b0;
    else if (sample_ready)
      opnd.valid <= sample_valid;  // refill or go empty
  end

  // operand register, loaded only on a sample transfer
  always_ff @(posedge trigger)
  begin
    if (take)
    begin
      opnd.tau_num <= dab_pkg::TURNS_DEN * phi_den_c;
      opnd.tau_den <= dab_pkg::TURNS_NUM * vdc2_w;
      opnd.phi_num <= dab_pkg::PHI_GAIN * fs_w * iref_w;
      opnd.phi_den <= phi_den_c;
    end
  end

  // held operands must not move under a stalled solver
  a_opnd_stable : assert property (@(posedge trigger) disable iff (!arst_n)
    opnd.valid && !opnd.ready |=> opnd.valid && $stable(opnd.tau_num) &&
    $stable(opnd.tau_den) && $stable(opnd.phi_num) && $stable(opnd.phi_den));

endmodule

`default_nettype wire

// ==== rtl/dab_mode_select.sv ====
`default_nettype none

module dab_mode_select
(
  input  wire                                   trigger,
  input  wire                                   arst_n,
  angle_if.sink                                 ang,
  output logic signed [dab_pkg::ANGLE_W-1:0]   tau1,
  output logic signed [dab_pkg::ANGLE_W-1:0]   tau2,
  output logic signed [dab_pkg::ANGLE_W-1:0]   phi,
  output logic [dab_pkg::MODE_W-1:0]           modo,
  output logic                                  update_done
);

  logic take;          // angle_if transfer
  logic tau_in_range;  // 0 <= tau2 <= pi
  logic phi_neg;
  logic phi_above;     // phi >= tau2 - pi
  logic mode_half;

  assign ang.ready = 1'b1;  // never stalls the solver
  assign take      = ang.valid && ang.ready;

  ////////////////////////////////////////////////////////////////////////////
  // mode 1 validity with tau1 fixed at half a period
  ////////////////////////////////////////////////////////////////////////////

  assign tau_in_range = (ang.tau2_full >= 0) && (ang.tau2_full <= dab_pkg::ANGLE_PI);
  assign phi_neg      = ang.phi_full < 0;
  assign phi_above    = ang.phi_full >= ang.tau2_full - dab_pkg::ANGLE_PI;
  assign mode_half    = ang.ok && tau_in_range && phi_neg && phi_above;

  always_ff @(posedge trigger or negedge arst_n)
  begin
    if (!arst_n)
    begin
      tau1        <= dab_pkg::RST_TAU1;
      tau2        <= dab_pkg::RST_TAU2;
      phi         <= dab_pkg::RST_PHI;
      modo        <= dab_pkg::MODE_HOLD;
      update_done <= 1'b0;
    end
    else
    begin
      update_done <= take;  // one cycle after the transfer
      if (take)
      begin
        if (mode_half)
        begin
          tau1 <= dab_pkg::ANGLE_PI[dab_pkg::ANGLE_W-1:0];
          tau2 <= ang.tau2_full[dab_pkg::ANGLE_W-1:0];  // range checked above
          phi  <= ang.phi_full[dab_pkg::ANGLE_W-1:0];   // between -pi and 0
          modo <= dab_pkg::MODE_HALF;
        end
        else
          modo <= dab_pkg::MODE_HOLD;  // angles keep last values
      end
    end
  end

  // update_done stays one cycle wide only if the solver drops valid after a transfer
  a_single_update : assert property (@(posedge trigger) disable iff (!arst_n)
    take |=> !take);

endmodule

`default_nettype wire

// ==== rtl/dab_modulator.sv ====
`default_nettype none

module dab_modulator
(
  input  wire                                   trigger,
  input  wire                                   arst_n,
  input  wire                                   sample_valid,
  input  wire signed [dab_pkg::VOLT_W-1:0]     vdc1,
  input  wire signed [dab_pkg::VOLT_W-1:0]     vdc2,
  input  wire signed [dab_pkg::VOLT_W-1:0]     iref,
  input  wire signed [dab_pkg::FS_W-1:0]       fs,
  output logic                                  sample_ready,
  output logic signed [dab_pkg::ANGLE_W-1:0]   tau1,
  output logic signed [dab_pkg::ANGLE_W-1:0]   tau2,
  output logic signed [dab_pkg::ANGLE_W-1:0]   phi,
  output logic [dab_pkg::MODE_W-1:0]           modo,
  output logic                                  update_done
);

  operand_if opnd_bus ();  // numerators and denominators
  angle_if   ang_bus ();   // full-width angles and ok flag

  ////////////////////////////////////////////////////////////////////////////
  // sample capture -> divisions -> mode decision
  ////////////////////////////////////////////////////////////////////////////

  dab_input_stage u_input
  (
    .trigger      (trigger),
    .arst_n       (arst_n),
    .sample_valid (sample_valid),
    .vdc1         (vdc1),
    .vdc2         (vdc2),
    .iref         (iref),
    .fs           (fs),
    .sample_ready (sample_ready),
    .opnd         (opnd_bus.source)
  );

  dab_angle_solver u_solver
  (
    .trigger (trigger),
    .arst_n  (arst_n),
    .opnd    (opnd_bus.sink),
    .ang     (ang_bus.source)
  );

  dab_mode_select u_mode
  (
    .trigger     (trigger),
    .arst_n      (arst_n),
    .ang         (ang_bus.sink),
    .tau1        (tau1),
    .tau2        (tau2),
    .phi         (phi),
    .modo        (modo),
    .update_done (update_done)
  );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f dab_modulator.f \
  --top-module tb_dab_modulator \
  -o tb_dab_modulator

./obj_dir/tb_dab_modulator | tee sim.log

if grep -q "Something failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation finished without failures"

// ==== verification/tb_dab_modulator.sv ====
`default_nettype none

module tb_dab_modulator;

  localparam int N_MODE1   = 120;  // spaced samples inside the mode 1 region
  localparam int N_BREAK   = 60;   // one mode 1 condition broken
  localparam int N_BAD     = 25;   // bad denominator, each followed by a good one
  localparam int N_B2B     = 170;  // valid held high
  localparam int N_SAMPLES = N_MODE1 + N_BREAK + 2 * N_BAD + N_B2B;
  localparam int TIMEOUT   = N_SAMPLES * 2 * (dab_pkg::DIV_W + 4) + 2000;

  logic                               trigger;
  logic                               arst_n;
  logic                               sample_valid;
  logic signed [dab_pkg::VOLT_W-1:0]  vdc1;
  logic signed [dab_pkg::VOLT_W-1:0]  vdc2;
  logic signed [dab_pkg::VOLT_W-1:0]  iref;
  logic signed [dab_pkg::FS_W-1:0]    fs;
  logic                               sample_ready;
  logic signed [dab_pkg::ANGLE_W-1:0] tau1;
  logic signed [dab_pkg::ANGLE_W-1:0] tau2;
  logic signed [dab_pkg::ANGLE_W-1:0] phi;
  logic [dab_pkg::MODE_W-1:0]         modo;
  logic                               update_done;

  longint q_vdc1[$];  // accepted samples, oldest first
  longint q_vdc2[$];
  longint q_iref[$];
  longint q_fs[$];
  longint m_tau1 = 255;  // model outputs, reset values
  longint m_tau2 = 147;
  longint m_phi  = -9;
  longint m_modo = 3;
  int     n_checks  = 0;
  int     n_errors  = 0;
  int     n_sent    = 0;
  int     n_updates = 0;
  int     cycles    = 0;
  bit     stall_seen = 1'b0;  // sample_ready low under a pending sample
  int unsigned seed_dummy;

  dab_modulator DUT
  (
    .trigger      (trigger),
    .arst_n       (arst_n),
    .sample_valid (sample_valid),
    .vdc1         (vdc1),
    .vdc2         (vdc2),
    .iref         (iref),
    .fs           (fs),
    .sample_ready (sample_ready),
    .tau1         (tau1),
    .tau2         (tau2),
    .phi          (phi),
    .modo         (modo),
    .update_done  (update_done)
  );

  initial
  begin
    trigger = 1'b0;
    forever
      #5 trigger = ~trigger;  // period 10
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare_value(input string what, input longint actual,
                               input longint expected);
    n_checks++;
    if (actual != expected)
    begin
      n_errors++;
      $display("Error at time %0t: %s is %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  function automatic int pick(input int lo, input int hi);
    return lo + int'($urandom % (hi - lo + 1));
  endfunction

  // equations and output rule, exact integer math
  task automatic apply_model(input longint v1, input longint v2, input longint ir,
                             input longint f);
    longint phi_den;
    longint tau_num;
    longint tau_den;
    longint phi_num;
    longint tau2f;
    longint phif;
    phi_den = 255 * v1 - 3 * f;
    tau_num = 2 * phi_den;
    tau_den = 11 * v2;
    phi_num = 5 * f * ir;
    m_modo  = 3;  // hold unless mode 1 proven
    if (tau_den > 0 && phi_den > 0)
    begin
      tau2f = tau_num / tau_den;  // truncates toward zero
      phif  = phi_num / phi_den - 128 + (tau2f >>> 1);
      if (tau2f >= 0 && tau2f <= 255 && phif < 0 && phif >= tau2f - 255)
      begin
        m_tau1 = 255;
        m_tau2 = tau2f;
        m_phi  = phif;
        m_modo = 1;
      end
    end
  endtask

  // called on a rising edge, returns on the edge that takes the sample
  task automatic send_sample(input int v1, input int v2, input int ir, input int f);
    bit taken;
    vdc1         <= v1[dab_pkg::VOLT_W-1:0];
    vdc2         <= v2[dab_pkg::VOLT_W-1:0];
    iref         <= ir[dab_pkg::VOLT_W-1:0];
    fs           <= f[dab_pkg::FS_W-1:0];
    sample_valid <= 1'b1;
    taken = 1'b0;
    while (!taken)
    begin
      @(negedge trigger);
      taken = sample_ready;
      @(posedge trigger);
    end
  endtask

  task automatic idle_cycles(input int n);
    sample_valid <= 1'b0;
    repeat (n) @(posedge trigger);
  endtask

  // vdc1 near n*vdc2, small negative iref
  task automatic send_mode1();
    int v2;
    v2 = pick(200, 999);
    send_sample(v2 * 11 / 2 - pick(0, 3), v2, -pick(1, 60), v2 * pick(2, 41));
  endtask

  task automatic send_break(input int k);
    int v2;
    v2 = pick(200, 999);
    if (k % 2 == 0)
      send_sample(v2 * 11 / 2 - pick(0, 3), v2, pick(2000, 8000), v2 * pick(2, 41));
    else  // negative fs pushes tau2 above pi
      send_sample(v2 * 11 / 2 - pick(0, 3), v2, -pick(1, 60), -v2 * pick(10, 40));
  endtask

  task automatic send_bad(input int k);
    if (k % 2 == 0)  // tau denominator zero or negative
      send_sample(pick(1000, 5000), (pick(0, 1) == 0) ? 0 : -pick(1, 500),
                  -pick(1, 60), pick(1000, 20000));
    else  // phi denominator not positive
      send_sample(pick(0, 50), pick(200, 999), -pick(1, 60), pick(5000, 20000));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // monitor, all sampling on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge trigger)
  begin
    if (sample_valid && !sample_ready)
      stall_seen = 1'b1;
    if (update_done)
    begin
      n_updates++;
      if (q_vdc1.size() == 0)
      begin
        n_errors++;
        $display("update_done pulsed at time %0t with no sample in flight", $time);
      end
      else
      begin
        apply_model(q_vdc1.pop_front(), q_vdc2.pop_front(), q_iref.pop_front(),
                    q_fs.pop_front());
        compare_value("tau1", tau1, m_tau1);
        compare_value("tau2", tau2, m_tau2);
        compare_value("phi", phi, m_phi);
        compare_value("modo", modo, m_modo);
      end
    end
    if (sample_valid && sample_ready)  // transfer on the next rising edge
    begin
      q_vdc1.push_back(vdc1);
      q_vdc2.push_back(vdc2);
      q_iref.push_back(iref);
      q_fs.push_back(fs);
      n_sent++;
    end
  end

  always @(posedge trigger)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT)
    begin
      $display("timeout after %0d cycles with %0d samples still waiting for an update",
               cycles, q_vdc1.size());
      $display("Something failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    int i;
    seed_dummy   = $urandom(13);
    arst_n       = 1'b0;
    sample_valid = 1'b0;
    vdc1         = '0;
    vdc2         = '0;
    iref         = '0;
    fs           = '0;
    repeat (3) @(posedge trigger);
    arst_n <= 1'b1;
    @(negedge trigger);
    compare_value("tau1 after reset", tau1, 255);
    compare_value("tau2 after reset", tau2, 147);
    compare_value("phi after reset", phi, -9);
    compare_value("modo after reset", modo, 3);
    compare_value("sample_ready after reset", sample_ready, 1);
    compare_value("update_done after reset", update_done, 0);
    @(posedge trigger);
    repeat (N_MODE1)
    begin
      send_mode1();
      idle_cycles(pick(0, 3));
    end
    for (i = 0; i < N_BREAK; i++)
    begin
      send_break(i);
      idle_cycles(pick(0, 3));
    end
    for (i = 0; i < N_BAD; i++)
    begin
      send_bad(i);
      send_mode1();  // design must keep accepting
      idle_cycles(pick(0, 3));
    end
    stall_seen = 1'b0;
    for (i = 0; i < N_B2B; i++)  // valid never drops here
    begin
      case (pick(0, 2))
        0: send_mode1();
        1: send_break(i);
        default: send_bad(i);
      endcase
    end
    idle_cycles(1);
    while (q_vdc1.size() != 0)
      @(posedge trigger);
    repeat (3) @(posedge trigger);
    if (!stall_seen)
    begin
      n_errors++;
      $display("sample_ready never fell while samples were sent back to back");
    end
    compare_value("update count", n_updates, n_sent);
    $display("samples %0d, updates %0d, checks %0d, errors %0d",
             n_sent, n_updates, n_checks, n_errors);
    if (n_errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire
